// File: Bender.yml
package:
  name: banked_ram

sources:
  - files:
      - source/mem_cfg_pkg.sv
      - source/mem_if_pkg.sv
      - source/bank_router.sv
      - source/ram_bank.sv
      - source/resp_merger.sv
      - source/banked_ram_top.sv
  - target: test
    files:
      - test/banked_ram_sva.sv
      - test/banked_ram_tb.sv

// File: banked_ram_top.f
source/mem_cfg_pkg.sv
source/mem_if_pkg.sv
source/bank_router.sv
source/ram_bank.sv
source/resp_merger.sv
source/banked_ram_top.sv
test/banked_ram_sva.sv
test/banked_ram_tb.sv

// File: source/bank_router.sv
// ------------------------------------------------------------
// bank router
// accepts host requests, decodes the bank from the low address
// bits and dispatches to one bank per cycle under read credits
// ------------------------------------------------------------
`default_nettype none

module bank_router #(
    parameter int NUM_BANKS    = 4,
    parameter int BANK_SEL_W   = 2,
    parameter int LOCAL_ADDR_W = 10
) (
    input  wire logic                                   ram_inf,
    input  wire logic                                   rst_n,
    input  wire mem_if_pkg::mem_req_t                   req,
    input  wire logic                                   req_valid,
    output logic                                        req_ready,
    input  wire logic                                   credit_free,
    output mem_if_pkg::bank_req_t [NUM_BANKS-1:0]       bank_req,
    output logic                                        rd_issue,
    output logic [BANK_SEL_W-1:0]                       rd_issue_bank
);

    import mem_cfg_pkg::*;
    import mem_if_pkg::*;

    localparam int CNT_W = $clog2(RESP_DEPTH + 1);

    logic [CNT_W-1:0]        credit_cnt;  // reads issued and not yet handed to the host
    logic                    accept;
    logic                    rd_accept;
    logic [BANK_SEL_W-1:0]   bank_sel;
    logic [LOCAL_ADDR_W-1:0] laddr;
    logic [NUM_BANKS-1:0]    bank_vld_q;  // one-hot dispatch strobe
    mem_op_e                 op_q;
    logic [ADDR_W-1:0]       laddr_q;
    logic [NUM_COLS-1:0]     col_en_q;
    ram_word_u               wdata_q;

    // ------------------------------------------------------------
    // address decode and acceptance
    assign bank_sel  = req.addr[BANK_SEL_W-1:0];           // low bits interleave the banks
    assign laddr     = req.addr[ADDR_W-1 -: LOCAL_ADDR_W]; // the rest addresses inside a bank

    // writes never need a credit, so they still pass when all credits are taken
    assign req_ready = (credit_cnt != CNT_W'(RESP_DEPTH)) || (req.op == OP_WRITE);
    assign accept    = req_valid && req_ready;
    assign rd_accept = accept && (req.op == OP_READ);

    // ------------------------------------------------------------
    // credit counter
    always_ff @(posedge ram_inf) begin
        if (!rst_n) begin
            credit_cnt <= '0;
        end else begin
            case ({rd_accept, credit_free})
                2'b10:   credit_cnt <= credit_cnt + CNT_W'(1); // read takes a buffer slot
                2'b01:   credit_cnt <= credit_cnt - CNT_W'(1); // host drained one response
                default: credit_cnt <= credit_cnt;             // none or both cancel out
            endcase
        end
    end

    // ------------------------------------------------------------
    // dispatch registers
    always_ff @(posedge ram_inf) begin
        if (!rst_n) begin
            bank_vld_q <= '0;
            rd_issue   <= 1'b0;
        end else begin
            bank_vld_q <= accept ? (NUM_BANKS'(1) << bank_sel) : '0;
            rd_issue   <= rd_accept;                           // tells the merger a read is on its way
        end
    end

    // payload is shared by all banks, only the strobe is per bank
    always_ff @(posedge ram_inf) begin
        if (accept) begin
            op_q          <= req.op;
            laddr_q       <= ADDR_W'(laddr);
            col_en_q      <= req.col_en;
            wdata_q       <= req.wdata;
            rd_issue_bank <= bank_sel;
        end
    end

    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_req[b].valid  = bank_vld_q[b];
            bank_req[b].op     = op_q;
            bank_req[b].laddr  = laddr_q;
            bank_req[b].col_en = col_en_q;
            bank_req[b].wdata  = wdata_q;
        end
    end

endmodule

`default_nettype wire

// File: source/banked_ram_top.sv
// ------------------------------------------------------------
// banked memory top level
// router, generated RAM banks and response merger behind one
// valid/ready request port and one valid/ready response port
// ------------------------------------------------------------
`default_nettype none

module banked_ram_top #(
    parameter int NUM_BANKS = 4
) (
    input  wire logic                  ram_inf,
    input  wire logic                  rst_n,
    input  wire mem_if_pkg::mem_req_t  req,
    input  wire logic                  req_valid,
    output logic                       req_ready,
    output mem_if_pkg::mem_resp_t      resp,
    output logic                       resp_valid,
    input  wire logic                  resp_ready
);

    import mem_cfg_pkg::*;
    import mem_if_pkg::*;

    localparam int BANK_SEL_W   = $clog2(NUM_BANKS);   // power of two banks only
    localparam int LOCAL_ADDR_W = ADDR_W - BANK_SEL_W;

    bank_req_t [NUM_BANKS-1:0] bank_req;
    mem_resp_t [NUM_BANKS-1:0] rd_data;
    logic [NUM_BANKS-1:0]      rd_valid;
    logic                      rd_issue;
    logic [BANK_SEL_W-1:0]     rd_issue_bank;
    logic                      credit_free;

    // ------------------------------------------------------------
    // request side
    bank_router #(
        .NUM_BANKS    (NUM_BANKS),
        .BANK_SEL_W   (BANK_SEL_W),
        .LOCAL_ADDR_W (LOCAL_ADDR_W)
    ) u_router (
        .ram_inf       (ram_inf),
        .rst_n         (rst_n),
        .req           (req),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .credit_free   (credit_free),
        .bank_req      (bank_req),
        .rd_issue      (rd_issue),
        .rd_issue_bank (rd_issue_bank)
    );

    // ------------------------------------------------------------
    // memory banks
    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
        ram_bank #(
            .LOCAL_ADDR_W (LOCAL_ADDR_W)
        ) u_bank (
            .ram_inf  (ram_inf),
            .rst_n    (rst_n),
            .bank_req (bank_req[g]),
            .rd_data  (rd_data[g]),
            .rd_valid (rd_valid[g])
        );
    end

    // ------------------------------------------------------------
    // response side
    resp_merger #(
        .NUM_BANKS  (NUM_BANKS),
        .RESP_DEPTH (RESP_DEPTH)
    ) u_merger (
        .ram_inf       (ram_inf),
        .rst_n         (rst_n),
        .rd_issue      (rd_issue),
        .rd_issue_bank (rd_issue_bank),
        .rd_data       (rd_data),
        .rd_valid      (rd_valid),
        .resp          (resp),
        .resp_valid    (resp_valid),
        .resp_ready    (resp_ready),
        .credit_free   (credit_free)
    );

endmodule

`default_nettype wire

// File: source/mem_cfg_pkg.sv
// ------------------------------------------------------------
// banked memory sizing constants
// address, column and data widths shared by the RTL and the
// testbench, plus response buffer depth and bank read latency
// ------------------------------------------------------------
`default_nettype none

package mem_cfg_pkg;

    // ------------------------------------------------------------
    // host address and storage word geometry
    localparam int ADDR_W   = 12;                 // host word address width
    localparam int COL_W    = 9;                  // one byte column incl. its spare bit
    localparam int NUM_COLS = 4;                  // columns per storage word
    localparam int WORD_W   = COL_W * NUM_COLS;   // 36-bit storage word
    localparam int DATA_W   = 32;                 // payload carried to the host
    localparam int RESP_W   = DATA_W + 1;         // mark bit on top of the data

    // ------------------------------------------------------------
    // flow control and pipeline depth
    localparam int RESP_DEPTH = 4;                // response buffer entries and read credits
    localparam int READ_LAT   = 2;                // ram register plus output register

endpackage

`default_nettype wire

// File: source/mem_if_pkg.sv
// ------------------------------------------------------------
// banked memory interface types
// request, bank request and response structs, plus the
// storage word union with its column and field views
// ------------------------------------------------------------
`default_nettype none

package mem_if_pkg;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mem_op_e;

    // ------------------------------------------------------------
    // one storage word, decoded either as columns or as fields
    typedef struct packed {
        logic [mem_cfg_pkg::WORD_W-mem_cfg_pkg::RESP_W-1:0] rsvd; // top bits, never returned
        logic                                               mark; // flag bit above the data
        logic [mem_cfg_pkg::DATA_W-1:0]                     data;
    } ram_fields_t;

    typedef union packed {
        logic [mem_cfg_pkg::NUM_COLS-1:0][mem_cfg_pkg::COL_W-1:0] cols; // write merge view
        ram_fields_t                                              fields; // read view
    } ram_word_u;

    // ------------------------------------------------------------
    // host request and response payloads
    typedef struct packed {
        mem_op_e                          op;
        logic [mem_cfg_pkg::ADDR_W-1:0]   addr;   // bank select sits in the low bits
        logic [mem_cfg_pkg::NUM_COLS-1:0] col_en; // one enable per 9-bit column
        ram_word_u                        wdata;
    } mem_req_t;

    typedef struct packed {
        logic                           valid;
        mem_op_e                        op;
        logic [mem_cfg_pkg::ADDR_W-1:0] laddr;  // local address, zero extended
        logic [mem_cfg_pkg::NUM_COLS-1:0] col_en;
        ram_word_u                      wdata;
    } bank_req_t;

    typedef struct packed {
        logic                           mark;
        logic [mem_cfg_pkg::DATA_W-1:0] data;
    } mem_resp_t;

endpackage

`default_nettype wire

// File: source/ram_bank.sv
// ------------------------------------------------------------
// single memory bank
// inferred RAM with 9-bit column enables on write and a
// registered read followed by an extra output register
// ------------------------------------------------------------
`default_nettype none

module ram_bank #(
    parameter int LOCAL_ADDR_W = 10
) (
    input  wire logic                  ram_inf,
    input  wire logic                  rst_n,
    input  wire mem_if_pkg::bank_req_t bank_req,
    output mem_if_pkg::mem_resp_t      rd_data,
    output logic                       rd_valid
);

    import mem_cfg_pkg::*;
    import mem_if_pkg::*;

    localparam int DEPTH = 2 ** LOCAL_ADDR_W;

    ram_word_u               mem [DEPTH];      // contents undefined until written
    ram_word_u               rd_word_q;        // first read stage, straight out of the array
    logic [LOCAL_ADDR_W-1:0] addr;
    logic                    wr_en;
    logic                    rd_en;
    logic [READ_LAT-1:0]     rd_vld_q;         // read strobe pipeline, one bit per stage

    assign addr  = bank_req.laddr[LOCAL_ADDR_W-1:0]; // upper bits are zero from the router
    assign wr_en = bank_req.valid && (bank_req.op == OP_WRITE);
    assign rd_en = bank_req.valid && (bank_req.op == OP_READ);

    // ------------------------------------------------------------
    // storage array
    always_ff @(posedge ram_inf) begin
        if (wr_en) begin
            for (int c = 0; c < NUM_COLS; c++) begin
                if (bank_req.col_en[c]) begin
                    mem[addr].cols[c] <= bank_req.wdata.cols[c]; // only enabled columns change
                end
            end
        end
    end

    always_ff @(posedge ram_inf) begin
        if (rd_en) begin
            rd_word_q <= mem[addr];                              // ram output register
        end
    end

    // ------------------------------------------------------------
    // output register
    // the reserved top bits are dropped here, the host only sees mark and data
    always_ff @(posedge ram_inf) begin
        if (rd_vld_q[0]) begin
            rd_data.mark <= rd_word_q.fields.mark;
            rd_data.data <= rd_word_q.fields.data;
        end
    end

    // ------------------------------------------------------------
    // read valid pipeline
    always_ff @(posedge ram_inf) begin
        if (!rst_n) begin
            rd_vld_q <= '0;
        end else begin
            rd_vld_q <= {rd_vld_q[READ_LAT-2:0], rd_en};         // back-to-back reads overlap
        end
    end

    assign rd_valid = rd_vld_q[READ_LAT-1];                      // lines up with rd_data

endmodule

`default_nettype wire

// File: source/resp_merger.sv
// ------------------------------------------------------------
// response merger
// tracks which bank each read went to, collects bank results
// in issue order into a small FIFO and returns read credits
// ------------------------------------------------------------
`default_nettype none

module resp_merger #(
    parameter int NUM_BANKS  = 4,
    parameter int RESP_DEPTH = 4
) (
    input  wire logic                                   ram_inf,
    input  wire logic                                   rst_n,
    input  wire logic                                   rd_issue,
    input  wire logic [$clog2(NUM_BANKS)-1:0]           rd_issue_bank,
    input  wire mem_if_pkg::mem_resp_t [NUM_BANKS-1:0]  rd_data,
    input  wire logic [NUM_BANKS-1:0]                   rd_valid,
    output mem_if_pkg::mem_resp_t                       resp,
    output logic                                        resp_valid,
    input  wire logic                                   resp_ready,
    output logic                                        credit_free
);

    import mem_cfg_pkg::*;
    import mem_if_pkg::*;

    localparam int SEL_W = $clog2(NUM_BANKS);
    localparam int PTR_W = $clog2(RESP_DEPTH);

    logic [READ_LAT-1:0]            iss_vld_q;   // a read is due from the bank below
    logic [READ_LAT-1:0][SEL_W-1:0] iss_bank_q;  // bank index travelling with each read
    logic [SEL_W-1:0]               sel_bank;
    logic                           push;
    logic                           pop;
    mem_resp_t                      fifo_mem [RESP_DEPTH];
    logic [PTR_W-1:0]               wr_ptr;
    logic [PTR_W-1:0]               rd_ptr;
    logic [PTR_W:0]                 fill;        // entries held, 0 to RESP_DEPTH

    // ------------------------------------------------------------
    // issue tracking
    // one read per cycle at most, so only the tracked bank can be valid now
    always_ff @(posedge ram_inf) begin
        if (!rst_n) begin
            iss_vld_q <= '0;
        end else begin
            iss_vld_q <= {iss_vld_q[READ_LAT-2:0], rd_issue};
        end
    end

    always_ff @(posedge ram_inf) begin
        iss_bank_q <= {iss_bank_q[READ_LAT-2:0], rd_issue_bank};
    end

    assign sel_bank = iss_bank_q[READ_LAT-1];
    assign push     = iss_vld_q[READ_LAT-1] && rd_valid[sel_bank];

    // ------------------------------------------------------------
    // response FIFO
    // credits bound the reads in flight, so a push never finds it full
    always_ff @(posedge ram_inf) begin
        if (push) begin
            fifo_mem[wr_ptr] <= rd_data[sel_bank];
        end
    end

    always_ff @(posedge ram_inf) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(RESP_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(RESP_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
            end
            case ({push, pop})
                2'b10:   fill <= fill + (PTR_W+1)'(1);
                2'b01:   fill <= fill - (PTR_W+1)'(1);
                default: fill <= fill;             // both at once leaves the count alone
            endcase
        end
    end

    assign resp        = fifo_mem[rd_ptr];         // head of the queue
    assign resp_valid  = (fill != '0);
    assign pop         = resp_valid && resp_ready;
    assign credit_free = pop;                      // slot is free again once the host takes it

endmodule

`default_nettype wire

// File: test/banked_ram_cases.txt
// op addr col_en wdata stall mark data lat  (op 0 read, 1 write; lat 0 is not checked)
// stall 1 lets the host drop resp_ready at random once the line is accepted
1 010 f 3deadbeef 0 0 00000000 0
0 010 0 000000000 0 1 deadbeef 3
1 020 f 011223344 0 0 00000000 0
1 020 5 fffffffff 0 0 00000000 0
0 020 0 000000000 0 0 17fe33ff 3
1 020 8 100000000 0 0 00000000 0
1 020 2 000000000 0 0 00000000 0
0 020 0 000000000 0 1 07fc01ff 3
1 100 f 0a0000000 0 0 00000000 0
1 101 f 1a1111111 0 0 00000000 0
1 102 f 0a2222222 0 0 00000000 0
1 103 f 1a3333333 0 0 00000000 0
0 100 0 000000000 0 0 a0000000 3
0 101 0 000000000 0 1 a1111111 3
0 102 0 000000000 0 0 a2222222 3
0 103 0 000000000 0 1 a3333333 3
0 103 0 000000000 0 1 a3333333 3
0 102 0 000000000 0 0 a2222222 3
0 101 0 000000000 0 1 a1111111 3
0 100 0 000000000 0 0 a0000000 3
0 010 0 000000000 0 1 deadbeef 3
0 100 0 000000000 1 0 a0000000 0
0 101 0 000000000 1 1 a1111111 0
0 102 0 000000000 1 0 a2222222 0
0 103 0 000000000 1 1 a3333333 0
0 010 0 000000000 1 1 deadbeef 0
1 030 f 10badc0de 1 0 00000000 0
0 030 0 000000000 1 1 0badc0de 0
0 020 0 000000000 1 1 07fc01ff 0
0 102 0 000000000 0 0 a2222222 0

// File: test/banked_ram_sva.sv
// ------------------------------------------------------------
// banked memory protocol assertions
// bound to the top level, checks payload stability under
// back-pressure, the post-reset response state and credits
// ------------------------------------------------------------
`default_nettype none

module banked_ram_sva (
    input wire logic                                         ram_inf,
    input wire logic                                         rst_n,
    input wire mem_if_pkg::mem_req_t                         req,
    input wire logic                                         req_valid,
    input wire logic                                         req_ready,
    input wire mem_if_pkg::mem_resp_t                        resp,
    input wire logic                                         resp_valid,
    input wire logic                                         resp_ready,
    input wire logic [$clog2(mem_cfg_pkg::RESP_DEPTH+1)-1:0] credit_cnt
);

    import mem_cfg_pkg::*;

    // a stalled request keeps its valid and its payload
    a_req_stable: assert property (@(posedge ram_inf) disable iff (!rst_n)
        req_valid && !req_ready |=> req_valid && $stable(req))
        else $error("request payload changed while stalled");

    // same rule on the response side, the merger must hold its head
    a_resp_stable: assert property (@(posedge ram_inf) disable iff (!rst_n)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp))
        else $error("response payload changed while stalled");

    a_resp_idle_after_reset: assert property (@(posedge ram_inf)
        $rose(rst_n) |-> !resp_valid)
        else $error("response valid set right after reset");

    a_credit_bound: assert property (@(posedge ram_inf) disable iff (!rst_n)
        credit_cnt <= RESP_DEPTH)
        else $error("credit count above buffer depth");

endmodule

bind banked_ram_top banked_ram_sva u_sva (
    .ram_inf    (ram_inf),
    .rst_n      (rst_n),
    .req        (req),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .resp       (resp),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .credit_cnt (u_router.credit_cnt)
);

`default_nettype wire

// File: test/banked_ram_tb.sv
// ------------------------------------------------------------
// banked memory testbench
// drives requests read from a cases file, scoreboards the
// responses in issue order and checks latency and credits
// ------------------------------------------------------------
`default_nettype none

module banked_ram_tb;

    import mem_cfg_pkg::*;
    import mem_if_pkg::*;

    localparam int PERIOD    = 100;
    localparam int FIELDS    = 8;     // op addr col_en wdata stall mark data lat
    localparam int MAX_CASES = 64;
    localparam int TIMEOUT   = 1000;  // cycles any single wait may take

    logic              ram_inf;
    logic              rst_n;
    mem_req_t          req;
    logic              req_valid;
    logic              req_ready;
    mem_resp_t         resp;
    logic              resp_valid;
    logic              resp_ready;

    logic [WORD_W-1:0] case_mem [MAX_CASES*FIELDS]; // unread entries stay unknown
    mem_resp_t         exp_q [$];                   // expected reads in issue order
    int                lat_q [$];                   // zero means latency is not checked
    time               acc_q [$];                   // accepting edge of each read
    logic              stall_mode;                  // host drops resp_ready at random
    logic              handshake_pending;           // a response leaves on the next edge
    logic              head_seen;
    int                err_resp;
    int                err_ctrl;
    int                err_lat;
    int                err_other;
    int                blocked_reads;
    int                num_cases;

    banked_ram_top #(
        .NUM_BANKS (4)
    ) uut (
        .ram_inf    (ram_inf),
        .rst_n      (rst_n),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .resp       (resp),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready)
    );

    initial begin
        ram_inf = 1'b0;
        forever begin
            #(PERIOD / 2) ram_inf = ~ram_inf;
        end
    end

    // ------------------------------------------------------------
    // compare and report helpers
    task automatic compare_resp(input string name, input mem_resp_t exp, input mem_resp_t act);
        if (act !== exp) begin
            err_resp++;
            $display("error t=%0t %s expected mark=%0b data=%h got mark=%0b data=%h",
                     $time, name, exp.mark, exp.data, act.mark, act.data);
        end
    endtask

    task automatic expect_ctrl(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            err_ctrl++;
            $display("error t=%0t %s expected %0b got %0b", $time, name, exp, act);
        end
    endtask

    task automatic verify_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            err_lat++;
            $display("error t=%0t %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic report_counts();
        $display("errors: resp=%0d ctrl=%0d latency=%0d other=%0d",
                 err_resp, err_ctrl, err_lat, err_other);
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        report_counts();
        $display("TB FAILED");
        $finish;
    endtask

    // ------------------------------------------------------------
    // request driver, holds valid until the DUT takes the request
    task automatic send_request(input int idx);
        logic [WORD_W-1:0] f [FIELDS];
        mem_req_t          r;
        mem_resp_t         exp;
        logic              exp_ready;
        logic              done;
        int                waited;
        for (int k = 0; k < FIELDS; k++) begin
            f[k] = case_mem[idx*FIELDS + k];
        end
        r.op      = mem_op_e'(f[0][0]);
        r.addr    = f[1][ADDR_W-1:0];
        r.col_en  = f[2][NUM_COLS-1:0];
        r.wdata   = f[3];
        exp.mark  = f[5][0];
        exp.data  = f[6][DATA_W-1:0];
        req       = r;
        req_valid = 1'b1;
        done      = 1'b0;
        waited    = 0;
        while (!done) begin
            @(posedge ram_inf);
            // credits in use are the reads queued here plus one leaving on this edge
            exp_ready = (r.op == OP_WRITE) ||
                        ((exp_q.size() + int'(handshake_pending)) < RESP_DEPTH);
            expect_ctrl("req_ready", exp_ready, req_ready);
            if (req_ready) begin
                done = 1'b1;
            end else begin
                if (r.op == OP_READ) blocked_reads++;
                waited++;
                if (waited > TIMEOUT) abort_run("timeout: a request was never accepted");
            end
        end
        if (r.op == OP_READ) begin
            exp_q.push_back(exp);
            lat_q.push_back(int'(f[7]));
            acc_q.push_back($time);
        end
        stall_mode = f[4][0];
        @(negedge ram_inf);
        req_valid = 1'b0;
    endtask

    // ------------------------------------------------------------
    // response side, resp and resp_valid hold from here to the next rising edge
    initial begin
        void'($urandom(26));
        forever begin
            @(negedge ram_inf);
            if (rst_n) begin
                resp_ready = stall_mode ? (($urandom % 4) == 0) : 1'b1;
                if (resp_valid && !head_seen) begin
                    head_seen = 1'b1;                     // first cycle this head is visible
                    if (exp_q.size() == 0) begin
                        err_other++;
                        $display("a response appeared with no read outstanding at t=%0t", $time);
                    end else if (lat_q[0] != 0) begin
                        verify_latency("resp_valid latency", lat_q[0],
                                       int'(($time - acc_q[0] - PERIOD / 2) / PERIOD));
                    end
                end
                if (!resp_ready) begin
                    for (int k = 0; k < lat_q.size(); k++) begin
                        lat_q[k] = 0;                     // a held head leaves no fixed latency
                    end
                end
                handshake_pending = resp_valid && resp_ready;
                if (handshake_pending) begin
                    head_seen = 1'b0;
                    if (exp_q.size() != 0) begin
                        compare_resp("resp", exp_q.pop_front(), resp);
                        void'(lat_q.pop_front());
                        void'(acc_q.pop_front());
                    end
                end
            end
        end
    end

    // ------------------------------------------------------------
    // main sequence
    initial begin
        int waited;
        rst_n             = 1'b0;
        req               = '0;
        req_valid         = 1'b0;
        resp_ready        = 1'b1;
        stall_mode        = 1'b0;
        handshake_pending = 1'b0;
        head_seen         = 1'b0;
        err_resp          = 0;
        err_ctrl          = 0;
        err_lat           = 0;
        err_other         = 0;
        blocked_reads     = 0;
        num_cases         = 0;
        $readmemh("test/banked_ram_cases.txt", case_mem);
        while (num_cases < MAX_CASES && !$isunknown(case_mem[num_cases*FIELDS])) begin
            num_cases++;
        end
        if (num_cases == 0) abort_run("no cases could be read from the cases file");
        repeat (5) @(negedge ram_inf);                    // reset spans five rising edges
        rst_n = 1'b1;
        @(negedge ram_inf);
        expect_ctrl("req_ready", 1'b1, req_ready);
        expect_ctrl("resp_valid", 1'b0, resp_valid);
        for (int i = 0; i < num_cases; i++) begin
            send_request(i);
        end
        waited = 0;
        while (exp_q.size() != 0 || resp_valid) begin
            @(negedge ram_inf);
            waited++;
            if (waited > TIMEOUT) abort_run("timeout: responses still outstanding at the end");
        end
        if (blocked_reads == 0) begin
            err_other++;
            $display("no read was ever held back by the credit limit");
        end
        report_counts();
        if (err_resp + err_ctrl + err_lat + err_other == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
